// File: common/gamePkg.sv
package gamePkg;

  // ####################################################################
  // types
  // ####################################################################

  typedef logic signed [10:0] coordT;  // pixel coordinate that may go negative.
  typedef logic [7:0] rgbT;            // rgb332.

  // ####################################################################
  // frame and object geometry
  // ####################################################################

  localparam coordT frameWidth  = 11'sd16;
  localparam coordT frameHeight = 11'sd12;

  localparam coordT playerWidth  = 11'sd4;
  localparam coordT playerHeight = 11'sd4;
  localparam coordT treeWidth    = 11'sd3;
  localparam coordT treeHeight   = 11'sd5;

  // colours from front to back.
  localparam rgbT playerColor     = 8'hE0;
  localparam rgbT treeColor       = 8'h1C;
  localparam rgbT backgroundColor = 8'h5C;

  // ####################################################################
  // coordinate buffer
  // ####################################################################

  localparam int fifoDepth = 4;

  typedef logic [$clog2(fifoDepth)-1:0] fifoPtrT;
  typedef logic [$clog2(fifoDepth):0] fifoCountT;  // one extra bit for full.

  localparam fifoCountT fifoFull = fifoCountT'(fifoDepth);

endpackage

// File: rtl/pixelScanner.sv
`timescale 1ns/1ns

module pixelScanner import gamePkg::*; (
  input  logic  clk,
  input  logic  rstN,
  input  logic  scanReady,
  output logic  scanValid,
  output coordT scanX,
  output coordT scanY,
  output logic  scanSof
);

  typedef enum logic {
    idle,
    scanning
  } scanStateT;

  scanStateT state;
  logic      transfer;
  logic      lastColumn;
  logic      lastRow;

  assign scanValid  = (state == scanning);
  assign transfer   = scanValid && scanReady;
  assign lastColumn = (scanX == frameWidth - 11'sd1);
  assign lastRow    = (scanY == frameHeight - 11'sd1);

  // only the top left pixel opens a frame.
  assign scanSof = (scanX == '0) && (scanY == '0);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= idle;
      scanX <= '0;
      scanY <= '0;
    end else begin
      case (state)
        idle: state <= scanning;  // start right after reset.
        scanning: begin
          if (transfer) begin
            if (lastColumn) begin
              scanX <= '0;
              scanY <= lastRow ? '0 : scanY + 11'sd1;
            end else begin
              scanX <= scanX + 11'sd1;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

// File: rtl/pixelFifo.sv
`timescale 1ns/1ns

module pixelFifo import gamePkg::*; (
  input  logic  clk,
  input  logic  rstN,
  input  logic  inValid,
  output logic  inReady,
  input  coordT inX,
  input  coordT inY,
  input  logic  inSof,
  output logic  outValid,
  input  logic  outReady,
  output coordT outX,
  output coordT outY,
  output logic  outSof
);

  coordT     xMem [fifoDepth];
  coordT     yMem [fifoDepth];
  logic      sofMem [fifoDepth];
  fifoPtrT   wrPtr;
  fifoPtrT   rdPtr;
  fifoCountT count;
  logic      push;
  logic      pop;

  assign outValid = (count != '0);
  // when full, a pop in the same cycle frees the slot being written.
  assign inReady  = (count != fifoFull) || outReady;
  assign push     = inValid && inReady;
  assign pop      = outValid && outReady;

  assign outX   = xMem[rdPtr];
  assign outY   = yMem[rdPtr];
  assign outSof = sofMem[rdPtr];

  // storage.
  always_ff @(posedge clk) begin
    if (push) begin
      xMem[wrPtr]   <= inX;
      yMem[wrPtr]   <= inY;
      sofMem[wrPtr] <= inSof;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push)
        wrPtr <= wrPtr + 1'b1;  // depth is a power of two so it wraps by itself.
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      count <= count + fifoCountT'(push) - fifoCountT'(pop);
    end
  end

endmodule

// File: render/objectDrawer.sv
`timescale 1ns/1ns

module objectDrawer import gamePkg::*; (
  input  coordT x,
  input  coordT y,
  input  coordT objX,
  input  coordT objY,
  input  coordT objWidth,
  input  coordT objHeight,
  output logic  request
);

  coordT xEnd;
  coordT yEnd;
  logic  insideX;
  logic  insideY;

  // first column and row past the object.
  assign xEnd = objX + objWidth;
  assign yEnd = objY + objHeight;

  // signed compares, so an object may hang off the top or left edge.
  assign insideX = (x >= objX) && (x < xEnd);
  assign insideY = (y >= objY) && (y < yEnd);

  assign request = insideX && insideY;

endmodule

// File: render/frameRenderer.sv
`timescale 1ns/1ns

module frameRenderer import gamePkg::*; (
  input  logic  clk,
  input  logic  rstN,
  input  logic  inValid,
  output logic  inReady,
  input  coordT inX,
  input  coordT inY,
  input  logic  inSof,
  input  coordT playerX,
  input  coordT playerY,
  input  coordT treeX,
  input  coordT treeY,
  input  logic  pixelReady,
  output logic  pixelValid,
  output coordT pixelX,
  output coordT pixelY,
  output logic  pixelSof,
  output rgbT   rgbOut,
  output logic  playerRequest,
  output logic  treeRequest,
  output logic  pixelTaken
);

  rgbT pixelColor;

  // ####################################################################
  // object hit tests on the fifo head
  // ####################################################################

  objectDrawer playerDrawer (
    .x(inX),
    .y(inY),
    .objX(playerX),
    .objY(playerY),
    .objWidth(playerWidth),
    .objHeight(playerHeight),
    .request(playerRequest)
  );

  objectDrawer treeDrawer (
    .x(inX),
    .y(inY),
    .objX(treeX),
    .objY(treeY),
    .objWidth(treeWidth),
    .objHeight(treeHeight),
    .request(treeRequest)
  );

  // player over tree over background.
  always_comb begin
    if (playerRequest)
      pixelColor = playerColor;
    else if (treeRequest)
      pixelColor = treeColor;
    else
      pixelColor = backgroundColor;
  end

  // ####################################################################
  // one-deep output stage
  // ####################################################################

  assign inReady    = !pixelValid || pixelReady;  // empty or draining now.
  assign pixelTaken = inValid && inReady;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      pixelValid <= 1'b0;
    else if (inReady)
      pixelValid <= inValid;
  end

  always_ff @(posedge clk) begin
    if (pixelTaken) begin
      pixelX   <= inX;
      pixelY   <= inY;
      pixelSof <= inSof;
      rgbOut   <= pixelColor;
    end
  end

endmodule

// File: rtl/collisionDetector.sv
`timescale 1ns/1ns

module collisionDetector (
  input  logic clk,
  input  logic rstN,
  input  logic pixelTaken,
  input  logic pixelSof,
  input  logic playerRequest,
  input  logic treeRequest,
  output logic hitPulse
);

  logic hitFlag;    // already hit in this frame.
  logic flagNow;
  logic overlap;

  assign overlap = playerRequest && treeRequest;
  // a new frame forgets the last hit, even on its own first pixel.
  assign flagNow = pixelSof ? 1'b0 : hitFlag;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      hitFlag  <= 1'b0;
      hitPulse <= 1'b0;
    end else if (pixelTaken) begin
      hitFlag  <= flagNow || overlap;
      hitPulse <= overlap && !flagNow;  // first overlap only.
    end else begin
      hitPulse <= 1'b0;
    end
  end

endmodule

// File: rtl/gameTop.sv
`timescale 1ns/1ns

module gameTop import gamePkg::*; (
  input  logic  clk,
  input  logic  rstN,
  input  coordT playerX,
  input  coordT playerY,
  input  coordT treeX,
  input  coordT treeY,
  input  logic  pixelReady,
  output logic  pixelValid,
  output coordT pixelX,
  output coordT pixelY,
  output logic  pixelSof,
  output rgbT   rgbOut,
  output logic  hitPulse
);

  logic  scanValid;
  logic  scanReady;
  coordT scanX;
  coordT scanY;
  logic  scanSof;

  logic  fifoValid;
  logic  fifoReady;
  coordT fifoX;
  coordT fifoY;
  logic  fifoSof;

  logic  playerRequest;
  logic  treeRequest;
  logic  pixelTaken;

  pixelScanner scanner (
    .clk(clk),
    .rstN(rstN),
    .scanReady(scanReady),
    .scanValid(scanValid),
    .scanX(scanX),
    .scanY(scanY),
    .scanSof(scanSof)
  );

  pixelFifo fifo (
    .clk(clk),
    .rstN(rstN),
    .inValid(scanValid),
    .inReady(scanReady),
    .inX(scanX),
    .inY(scanY),
    .inSof(scanSof),
    .outValid(fifoValid),
    .outReady(fifoReady),
    .outX(fifoX),
    .outY(fifoY),
    .outSof(fifoSof)
  );

  frameRenderer renderer (
    .clk(clk),
    .rstN(rstN),
    .inValid(fifoValid),
    .inReady(fifoReady),
    .inX(fifoX),
    .inY(fifoY),
    .inSof(fifoSof),
    .playerX(playerX),
    .playerY(playerY),
    .treeX(treeX),
    .treeY(treeY),
    .pixelReady(pixelReady),
    .pixelValid(pixelValid),
    .pixelX(pixelX),
    .pixelY(pixelY),
    .pixelSof(pixelSof),
    .rgbOut(rgbOut),
    .playerRequest(playerRequest),
    .treeRequest(treeRequest),
    .pixelTaken(pixelTaken)
  );

  // sof of the pixel being taken from the fifo head.
  collisionDetector collision (
    .clk(clk),
    .rstN(rstN),
    .pixelTaken(pixelTaken),
    .pixelSof(fifoSof),
    .playerRequest(playerRequest),
    .treeRequest(treeRequest),
    .hitPulse(hitPulse)
  );

endmodule

// File: verification/gameTop_assert.sv
`timescale 1ns/1ns

module gameTopAssert import gamePkg::*; (
  input logic  clk,
  input logic  rstN,
  input logic  scanValid,
  input logic  scanReady,
  input coordT scanX,
  input coordT scanY,
  input logic  scanSof,
  input logic  pixelValid,
  input logic  pixelReady,
  input coordT pixelX,
  input coordT pixelY,
  input logic  pixelSof,
  input rgbT   rgbOut,
  input logic  hitPulse
);

  // a stalled transfer keeps valid and its data.
  scanHold: assert property (@(posedge clk) disable iff (!rstN)
    scanValid && !scanReady |=> scanValid && $stable(scanX) && $stable(scanY)
      && $stable(scanSof)) else $error("scan stream changed while stalled");

  pixelHold: assert property (@(posedge clk) disable iff (!rstN)
    pixelValid && !pixelReady |=> pixelValid && $stable(pixelX) && $stable(pixelY)
      && $stable(pixelSof) && $stable(rgbOut)) else $error("pixel stream changed while stalled");

  hitOneCycle: assert property (@(posedge clk) disable iff (!rstN)
    hitPulse |=> !hitPulse) else $error("hitPulse longer than one cycle");

  // the frame flag has to survive the buffer and the output stage.
  sofAtOrigin: assert property (@(posedge clk) disable iff (!rstN)
    pixelValid |-> pixelSof == ((pixelX == '0) && (pixelY == '0)))
    else $error("pixelSof off the origin");

endmodule

bind gameTop gameTopAssert checks (.*);

// File: verification/gameTopTb.sv
`timescale 1ns/1ns

module gameTopTb import gamePkg::*;;

  localparam int testCount   = 5;
  localparam int framePixels = int'(frameWidth) * int'(frameHeight);
  localparam int cycleLimit  = 4 * testCount * framePixels * 4;

  logic  clk;
  logic  rstN;
  coordT playerX;
  coordT playerY;
  coordT treeX;
  coordT treeY;
  logic  pixelReady;
  logic  pixelValid;
  coordT pixelX;
  coordT pixelY;
  logic  pixelSof;
  rgbT   rgbOut;
  logic  hitPulse;
  int    expX;        // reference raster position.
  int    expY;
  int    cycleCount;
  int    hits;

  gameTop uut (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("timeout, the pixel stream did not finish within %0d cycles", cycleLimit);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  // ####################################################################
  // compare tasks and reference model
  // ####################################################################

  task automatic compareCoord(input string name, input coordT expected, input coordT actual);
    if (actual !== expected) begin
      $display("error %s expected 0x%0h got 0x%0h", name, expected, actual);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic compareRgb(input string name, input rgbT expected, input rgbT actual);
    if (actual !== expected) begin
      $display("error %s expected 0x%0h got 0x%0h", name, expected, actual);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic compareBit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("error %s expected 0x%0h got 0x%0h", name, expected, actual);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  function automatic logic insideRect(input int x, input int y, input coordT left,
                                      input coordT top, input coordT width, input coordT height);
    int right;
    int bottom;
    right  = int'(left) + int'(width);
    bottom = int'(top) + int'(height);
    return (x >= int'(left)) && (x < right) && (y >= int'(top)) && (y < bottom);
  endfunction

  function automatic rgbT expectedColor(input int x, input int y);
    if (insideRect(x, y, playerX, playerY, playerWidth, playerHeight))
      return playerColor;
    if (insideRect(x, y, treeX, treeY, treeWidth, treeHeight))
      return treeColor;
    return backgroundColor;
  endfunction

  task automatic checkPixel();
    compareCoord("pixelX", coordT'(expX), pixelX);
    compareCoord("pixelY", coordT'(expY), pixelY);
    compareBit("pixelSof", (expX == 0) && (expY == 0), pixelSof);
    compareRgb("rgbOut", expectedColor(expX, expY), rgbOut);
    expX++;
    if (expX == int'(frameWidth)) begin
      expX = 0;
      expY = (expY == int'(frameHeight) - 1) ? 0 : expY + 1;
    end
  endtask

  // ####################################################################
  // stimulus
  // ####################################################################

  task automatic setObjects(input int px, input int py, input int tx, input int ty);
    @(negedge clk);
    playerX = coordT'(px);
    playerY = coordT'(py);
    treeX   = coordT'(tx);
    treeY   = coordT'(ty);
  endtask

  task automatic applyReset();
    @(negedge clk);
    rstN       = 1'b0;
    pixelReady = 1'b0;
    repeat (4) begin
      @(negedge clk);
      compareBit("pixelValid", 1'b0, pixelValid);
      compareBit("hitPulse", 1'b0, hitPulse);
    end
    rstN = 1'b1;
    expX = 0;
    expY = 0;
  endtask

  // a pixel seen valid here with ready set is taken on the next rising edge.
  task automatic takePixels(input int total, input logic randomReady, output int hitCount);
    int   taken;
    logic ready;
    taken    = 0;
    hitCount = 0;
    while (taken < total) begin
      @(negedge clk);
      ready      = randomReady ? logic'(($urandom % 3) != 0) : 1'b1;
      pixelReady = ready;
      if (hitPulse)
        hitCount++;
      if (pixelValid && ready) begin
        checkPixel();
        taken++;
      end
    end
  endtask

  task automatic testReset();
    setObjects(1, 1, 10, 5);
    applyReset();
    @(negedge clk);
    compareBit("pixelValid", 1'b0, pixelValid);
    compareBit("hitPulse", 1'b0, hitPulse);
    takePixels(1, 1'b0, hits);  // must be the origin.
  endtask

  task automatic testRasterOrder();
    setObjects(1, 1, 10, 5);
    applyReset();
    takePixels(2 * framePixels, 1'b0, hits);
  endtask

  task automatic testColors();
    setObjects(-2, -1, 1, -2);  // both hang off the top left corner.
    applyReset();
    takePixels(framePixels, 1'b0, hits);
  endtask

  task automatic testBackPressure();
    setObjects(14, 9, 12, 8);  // clipped at right and bottom.
    applyReset();
    takePixels(3 * framePixels, 1'b1, hits);
  endtask

  task automatic testCollision();
    setObjects(5, 4, 7, 6);
    applyReset();
    repeat (2) begin
      takePixels(framePixels, 1'b0, hits);
      compareBit("hitPulse", 1'b1, hits == 1);
    end
    setObjects(1, 1, 10, 5);
    applyReset();
    repeat (2) begin
      takePixels(framePixels, 1'b0, hits);
      compareBit("hitPulse", 1'b0, hits != 0);
    end
  endtask

  initial begin
    clk        = 1'b0;
    rstN       = 1'b0;
    pixelReady = 1'b0;
    playerX    = '0;
    playerY    = '0;
    treeX      = '0;
    treeY      = '0;
    cycleCount = 0;
    void'($urandom(4));
    testReset();
    testRasterOrder();
    testColors();
    testBackPressure();
    testCollision();
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: verilog.f
common/gamePkg.sv
rtl/pixelScanner.sv
rtl/pixelFifo.sv
render/objectDrawer.sv
render/frameRenderer.sv
rtl/collisionDetector.sv
rtl/gameTop.sv
verification/gameTop_assert.sv
verification/gameTopTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= gameTopTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)
